// ==== common/stream_pkg.sv ====
// Beat format shared by every pipeline stage; import wherever beat fields are declared
`default_nettype none

package stream_pkg;

  // Data path width in bits
  localparam int tdata_w = 64;

  // One keep bit per data byte
  localparam int tkeep_w = tdata_w / 8;

  // User sideband width
  localparam int tuser_w = 32;

  // Gap field inside the user sideband of a first beat
  // Holds the tick distance to the next packet start
  localparam int gap_lsb = 0;
  localparam int gap_field_w = 16;

  // Field must fit within the sideband
  localparam int gap_msb = gap_lsb + gap_field_w - 1;

endpackage : stream_pkg

`default_nettype wire

// ==== common/pace_pkg.sv ====
// Timer widths and pacer state encoding; import in the pacer and at the top level
`default_nettype none

package pace_pkg;

  // Tick counter and deadline width
  // Compare is wrap-safe, so this only bounds the longest gap
  localparam int tick_w = 32;

  // Register gap value width, same as the sideband gap field
  localparam int gap_w = 16;

  // Pacer position within a packet
  //   st_header  next beat opens a packet, subject to pacing
  //   st_body    next beat continues the current packet
  typedef enum logic {
    st_header = 1'b0,
    st_body   = 1'b1
  } pace_state_e;

endpackage : pace_pkg

`default_nettype wire

// ==== hdl/ingress_buffer.sv ====
// Fall-through beat FIFO in front of the pacer; returns one upstream credit per popped beat
`default_nettype none

module ingress_buffer
  import stream_pkg::*;
#(
  parameter int ingress_depth = 8
) (
  input  logic               axi_aclk,
  input  logic               rst_n,
  // Upstream, credit based
  input  logic               s_valid,
  input  logic [tdata_w-1:0] s_data,
  input  logic [tkeep_w-1:0] s_keep,
  input  logic [tuser_w-1:0] s_user,
  input  logic               s_last,
  output logic               s_credit,
  // Buffer head toward the pacer
  output logic               head_valid,
  output logic [tdata_w-1:0] head_data,
  output logic [tkeep_w-1:0] head_keep,
  output logic [tuser_w-1:0] head_user,
  output logic               head_last,
  input  logic               head_pop
);

  localparam int ptr_w = $clog2(ingress_depth);

  // Beat storage, one array per field
  logic [tdata_w-1:0] mem_data [ingress_depth];
  logic [tkeep_w-1:0] mem_keep [ingress_depth];
  logic [tuser_w-1:0] mem_user [ingress_depth];
  logic               mem_last [ingress_depth];

  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0]   count;

  // Credit protocol guarantees a free slot on every push
  always_ff @(posedge axi_aclk) begin
    if (s_valid) begin
      mem_data[wr_ptr] <= s_data;
      mem_keep[wr_ptr] <= s_keep;
      mem_user[wr_ptr] <= s_user;
      mem_last[wr_ptr] <= s_last;
    end
  end

  // Pointers, occupancy and the credit return
  always_ff @(posedge axi_aclk) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      s_credit <= 1'b0;
    end else begin
      if (s_valid) wr_ptr <= wr_ptr + 1'b1;
      if (head_pop) rd_ptr <= rd_ptr + 1'b1;
      // Simultaneous push and pop leaves occupancy unchanged
      case ({s_valid, head_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Freed slot goes back upstream one cycle later
      s_credit <= head_pop;
    end
  end

  // Fall-through head, valid as soon as a beat is stored
  assign head_valid = (count != '0);
  assign head_data  = mem_data[rd_ptr];
  assign head_keep  = mem_keep[rd_ptr];
  assign head_user  = mem_user[rd_ptr];
  assign head_last  = mem_last[rd_ptr];

endmodule : ingress_buffer

`default_nettype wire

// ==== pacer/gap_timer.sv ====
// Tick counter and release deadline for the pacer; release_ok allows the next packet start
`default_nettype none

module gap_timer
  import pace_pkg::*;
(
  input  logic             axi_aclk,
  input  logic             rst_n,
  input  logic             sw_rst,
  // Deadline load from the pacer
  input  logic             load_gap,
  input  logic [gap_w-1:0] gap_ticks,
  // Next packet may start
  output logic             release_ok
);

  logic [tick_w-1:0] tick_cnt;
  logic [tick_w-1:0] deadline;
  logic [tick_w-1:0] tick_diff;
  logic              expired;

  // Signed distance from deadline, wraps cleanly
  assign tick_diff = tick_cnt - deadline;

  // Sticky once reached, so a long idle period cannot wrap back to blocked
  assign release_ok = expired | ~tick_diff[tick_w-1];

  always_ff @(posedge axi_aclk) begin
    if (!rst_n || sw_rst) begin
      tick_cnt <= '0;
      deadline <= '0;
      expired  <= 1'b0;
    end else begin
      // Free-running, one tick per clock
      tick_cnt <= tick_cnt + 1'b1;
      if (load_gap) begin
        // Gap measured from the start of the current packet
        deadline <= tick_cnt + tick_w'(gap_ticks);
        expired  <= 1'b0;
      end else if (!tick_diff[tick_w-1]) begin
        expired <= 1'b1;
      end
    end
  end

endmodule : gap_timer

`default_nettype wire

// ==== pacer/pacer_fsm.sv ====
// Second stage: moves beats from buffer head to egress, holding packet starts until the gap ends
`default_nettype none

module pacer_fsm
  import stream_pkg::*;
  import pace_pkg::*;
(
  input  logic               axi_aclk,
  input  logic               rst_n,
  input  logic               sw_rst,
  // Pacing controls
  input  logic               ipd_en,
  input  logic               use_reg_val,
  input  logic [gap_w-1:0]   delay_reg_val,
  // Buffer head
  input  logic               head_valid,
  input  logic [tdata_w-1:0] head_data,
  input  logic [tkeep_w-1:0] head_keep,
  input  logic [tuser_w-1:0] head_user,
  input  logic               head_last,
  output logic               head_pop,
  // Toward egress
  output logic               out_valid,
  output logic [tdata_w-1:0] out_data,
  output logic [tkeep_w-1:0] out_keep,
  output logic [tuser_w-1:0] out_user,
  output logic               out_last,
  input  logic               out_ready
);

  pace_state_e state;

  logic             beat_ok;
  logic             load_gap;
  logic [gap_w-1:0] gap_ticks;
  logic             release_ok;

  // Deadline tracking for packet starts
  gap_timer u_gap_timer (
    .axi_aclk   (axi_aclk),
    .rst_n      (rst_n),
    .sw_rst     (sw_rst),
    .load_gap   (load_gap),
    .gap_ticks  (gap_ticks),
    .release_ok (release_ok)
  );

  // First beat waits for the deadline unless pacing is off
  // Body beats only need egress credit
  always_comb begin
    if (state == st_header) begin
      beat_ok = release_ok || !ipd_en;
    end else begin
      beat_ok = 1'b1;
    end
  end

  // Offer and pop in the same cycle, so the head is never copied
  assign out_valid = head_valid && beat_ok;
  assign head_pop  = out_valid && out_ready;

  // Beats forwarded unchanged
  assign out_data = head_data;
  assign out_keep = head_keep;
  assign out_user = head_user;
  assign out_last = head_last;

  // Gap for the next packet, taken from the first beat or the register
  assign gap_ticks = use_reg_val ? delay_reg_val : head_user[gap_msb:gap_lsb];

  // Arm the deadline only on a paced packet start
  assign load_gap = head_pop && ipd_en && (state == st_header);

  always_ff @(posedge axi_aclk) begin
    if (!rst_n || sw_rst) begin
      state <= st_header;
    end else if (head_pop) begin
      // Last beat closes the packet, anything else continues it
      if (head_last) begin
        state <= st_header;
      end else begin
        state <= st_body;
      end
    end
  end

endmodule : pacer_fsm

`default_nettype wire

// ==== hdl/credit_egress.sv ====
// Third stage: output register and downstream credit count; drives the m_ strobe interface
`default_nettype none

module credit_egress
  import stream_pkg::*;
#(
  parameter int egress_credit_w = 4
) (
  input  logic               axi_aclk,
  input  logic               rst_n,
  // From the pacer
  input  logic               out_valid,
  input  logic [tdata_w-1:0] out_data,
  input  logic [tkeep_w-1:0] out_keep,
  input  logic [tuser_w-1:0] out_user,
  input  logic               out_last,
  output logic               out_ready,
  // Downstream, credit based, no ready
  output logic               m_valid,
  output logic [tdata_w-1:0] m_data,
  output logic [tkeep_w-1:0] m_keep,
  output logic [tuser_w-1:0] m_user,
  output logic               m_last,
  input  logic               m_credit
);

  logic [egress_credit_w-1:0] credit_cnt;
  logic                       xfer;

  // Output register reloads every cycle, so a credit is the only condition
  assign out_ready = (credit_cnt != '0);
  assign xfer      = out_valid && out_ready;

  // Credit count and beat strobe
  always_ff @(posedge axi_aclk) begin
    if (!rst_n) begin
      credit_cnt <= '0;
      m_valid    <= 1'b0;
    end else begin
      // Grant and spend in one cycle cancel out
      case ({m_credit, xfer})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
      // One strobe per transferred beat
      m_valid <= xfer;
    end
  end

  // Payload held until the next transfer
  always_ff @(posedge axi_aclk) begin
    if (xfer) begin
      m_data <= out_data;
      m_keep <= out_keep;
      m_user <= out_user;
      m_last <= out_last;
    end
  end

endmodule : credit_egress

`default_nettype wire

// ==== hdl/pkt_pacer_top.sv ====
// Packet pacer top level: ingress buffer, pacer and credit egress in a three-stage pipeline
`default_nettype none

module pkt_pacer_top
  import stream_pkg::*;
  import pace_pkg::*;
#(
  parameter int ingress_depth   = 8,
  parameter int egress_credit_w = 4
) (
  input  logic               axi_aclk,
  input  logic               rst_n,
  input  logic               sw_rst,
  input  logic               ipd_en,
  input  logic               use_reg_val,
  input  logic [gap_w-1:0]   delay_reg_val,
  // Upstream
  input  logic               s_valid,
  input  logic [tdata_w-1:0] s_data,
  input  logic [tkeep_w-1:0] s_keep,
  input  logic [tuser_w-1:0] s_user,
  input  logic               s_last,
  output logic               s_credit,
  // Downstream
  output logic               m_valid,
  output logic [tdata_w-1:0] m_data,
  output logic [tkeep_w-1:0] m_keep,
  output logic [tuser_w-1:0] m_user,
  output logic               m_last,
  input  logic               m_credit
);

  // Buffer head
  logic               head_valid;
  logic [tdata_w-1:0] head_data;
  logic [tkeep_w-1:0] head_keep;
  logic [tuser_w-1:0] head_user;
  logic               head_last;
  logic               head_pop;

  // Pacer to egress
  logic               out_valid;
  logic [tdata_w-1:0] out_data;
  logic [tkeep_w-1:0] out_keep;
  logic [tuser_w-1:0] out_user;
  logic               out_last;
  logic               out_ready;

  ingress_buffer #(
    .ingress_depth (ingress_depth)
  ) u_ingress (
    .axi_aclk   (axi_aclk),
    .rst_n      (rst_n),
    .s_valid    (s_valid),
    .s_data     (s_data),
    .s_keep     (s_keep),
    .s_user     (s_user),
    .s_last     (s_last),
    .s_credit   (s_credit),
    .head_valid (head_valid),
    .head_data  (head_data),
    .head_keep  (head_keep),
    .head_user  (head_user),
    .head_last  (head_last),
    .head_pop   (head_pop)
  );

  pacer_fsm u_pacer (
    .axi_aclk      (axi_aclk),
    .rst_n         (rst_n),
    .sw_rst        (sw_rst),
    .ipd_en        (ipd_en),
    .use_reg_val   (use_reg_val),
    .delay_reg_val (delay_reg_val),
    .head_valid    (head_valid),
    .head_data     (head_data),
    .head_keep     (head_keep),
    .head_user     (head_user),
    .head_last     (head_last),
    .head_pop      (head_pop),
    .out_valid     (out_valid),
    .out_data      (out_data),
    .out_keep      (out_keep),
    .out_user      (out_user),
    .out_last      (out_last),
    .out_ready     (out_ready)
  );

  credit_egress #(
    .egress_credit_w (egress_credit_w)
  ) u_egress (
    .axi_aclk  (axi_aclk),
    .rst_n     (rst_n),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_keep  (out_keep),
    .out_user  (out_user),
    .out_last  (out_last),
    .out_ready (out_ready),
    .m_valid   (m_valid),
    .m_data    (m_data),
    .m_keep    (m_keep),
    .m_user    (m_user),
    .m_last    (m_last),
    .m_credit  (m_credit)
  );

endmodule : pkt_pacer_top

`default_nettype wire

// ==== dv/pkt_pacer_props.sv ====
// Credit counter properties for the egress stage, attached to every credit_egress by bind
`default_nettype none

module pkt_pacer_props #(
  parameter int egress_credit_w = 4
) (
  input logic                       axi_aclk,
  input logic                       rst_n,
  input logic                       out_valid,
  input logic                       out_ready,
  input logic                       m_valid,
  input logic                       m_credit,
  input logic [egress_credit_w-1:0] credit_cnt
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int cnt_w = egress_credit_w + 1;

  logic             xfer;
  logic [cnt_w-1:0] port_credits;

  assign xfer = out_valid && out_ready;

  // Credits seen on the port minus strobes sent, one bit wider than the counter
  always_ff @(posedge axi_aclk) begin
    if (!rst_n) begin
      port_credits <= '0;
    end else begin
      port_credits <= port_credits + cnt_w'(m_credit) - cnt_w'(m_valid);
    end
  end

  // Each strobe needs a credit granted before its transfer cycle
  a_no_xfer_without_credit : assert property (@(posedge axi_aclk) disable iff (!rst_n)
    m_valid |-> (port_credits > cnt_w'($past(m_credit))))
    else $error("Egress beat sent without a downstream credit");

  // Count at its maximum takes no further credit
  a_no_overflow : assert property (@(posedge axi_aclk) disable iff (!rst_n)
    (credit_cnt == '1) |-> !(m_credit && !xfer))
    else $error("Egress credit count wraps above its maximum");

  // Strobe quiet while held in reset
  a_quiet_in_reset : assert property (@(posedge axi_aclk) !rst_n |=> !m_valid)
    else $error("m_valid high during reset");

endmodule : pkt_pacer_props

bind credit_egress pkt_pacer_props #(.egress_credit_w(egress_credit_w)) u_props (
  .axi_aclk   (axi_aclk),
  .rst_n      (rst_n),
  .out_valid  (out_valid),
  .out_ready  (out_ready),
  .m_valid    (m_valid),
  .m_credit   (m_credit),
  .credit_cnt (credit_cnt)
);

`default_nettype wire

// ==== dv/pkt_pacer_tb.sv ====
// Testbench for the packet pacer; random packets checked against a queue model and pacing rules
`default_nettype none

module pkt_pacer_tb;
  timeunit 1ns;
  timeprecision 1ps;

  logic         axi_aclk;
  logic         rst_n;
  logic         sw_rst;
  logic         ipd_en;
  logic         use_reg_val;
  logic [15:0]  delay_reg_val;
  logic         s_valid;
  logic [63:0]  s_data;
  logic [7:0]   s_keep;
  logic [31:0]  s_user;
  logic         s_last;
  logic         s_credit;
  logic         m_valid;
  logic [63:0]  m_data;
  logic [7:0]   m_keep;
  logic [31:0]  m_user;
  logic         m_last;
  logic         m_credit;

  // Model state
  logic [104:0] exp_q[$];
  logic [104:0] exp_b;
  int unsigned  lcg_state;
  int           cyc;
  int           err_cnt;
  int           other_err;
  int           up_credits;
  int           credit_returns;
  int           beats_sent;
  int           granted;
  int           mbeats;
  int           prev_start;
  int           prev_gap;
  int           last_start;
  int           last_drive;
  int           sw_cyc;
  bit           prev_valid;
  bit           out_first;
  bit           upper_chk;
  bit           grant_on;
  bit           grant_fast;
  bit           grant_next;

  pkt_pacer_top #(
    .ingress_depth   (8),
    .egress_credit_w (4)
  ) dut (
    .axi_aclk      (axi_aclk),
    .rst_n         (rst_n),
    .sw_rst        (sw_rst),
    .ipd_en        (ipd_en),
    .use_reg_val   (use_reg_val),
    .delay_reg_val (delay_reg_val),
    .s_valid       (s_valid),
    .s_data        (s_data),
    .s_keep        (s_keep),
    .s_user        (s_user),
    .s_last        (s_last),
    .s_credit      (s_credit),
    .m_valid       (m_valid),
    .m_data        (m_data),
    .m_keep        (m_keep),
    .m_user        (m_user),
    .m_last        (m_last),
    .m_credit      (m_credit)
  );

  // Cycle count moves just before each rising edge
  initial begin
    axi_aclk = 1'b0;
    forever begin
      #4 axi_aclk = 1'b0;
      #4 begin
        cyc = cyc + 1;
        axi_aclk = 1'b1;
      end
    end
  end

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 8;
  endfunction

  task automatic check_eq(input string name, input logic [127:0] exp, input logic [127:0] act);
    if (exp !== act) begin
      err_cnt++;
      $display("Fail %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  // Downstream credit pulse, decided at the falling edge before
  always @(posedge axi_aclk) begin
    m_credit <= grant_next;
  end

  // Output monitor, sampled away from the rising edge
  always @(negedge axi_aclk) begin
    if (rst_n) begin
      if (s_credit) begin
        up_credits++;
        credit_returns++;
      end
      if (m_valid) begin
        mbeats++;
        if (mbeats > granted) begin
          other_err++;
          $display("More output beats than downstream credits granted");
        end
        if (exp_q.size() == 0) begin
          other_err++;
          $display("Output beat seen while none was expected");
        end else begin
          exp_b = exp_q.pop_front();
          check_eq("beat", 128'(exp_b), 128'({m_last, m_user, m_keep, m_data}));
          if (out_first) begin
            // Packet start spacing against the earlier packet's gap
            if (ipd_en && prev_valid && (cyc - prev_start < prev_gap)) begin
              err_cnt++;
              $display("Fail gap_min: expected %0d, actual %0d", prev_gap, cyc - prev_start);
            end
            if (ipd_en && prev_valid && upper_chk && (cyc - prev_start > prev_gap + 2)) begin
              err_cnt++;
              $display("Fail gap_max: expected %0d, actual %0d", prev_gap + 2, cyc - prev_start);
            end
            prev_start = cyc;
            prev_gap   = use_reg_val ? int'(delay_reg_val) : int'(exp_b[87:72]);
            prev_valid = ipd_en;
            last_start = cyc;
          end
          out_first = m_last;
        end
      end
    end
    // Next downstream credit, keeps the 4-bit egress count from wrapping
    if (rst_n && grant_on && (granted - mbeats < 14) &&
        (grant_fast || next_rand() % 8 == 0)) begin
      grant_next = 1'b1;
      granted    = granted + 1;
    end else begin
      grant_next = 1'b0;
    end
  end

  // One beat, sent as soon as an upstream credit is held
  task automatic drive_beat(input logic [104:0] b);
    int t = 0;
    @(posedge axi_aclk);
    while (up_credits == 0 && t < 2000) begin
      s_valid <= 1'b0;
      @(posedge axi_aclk);
      t++;
    end
    if (up_credits == 0) begin
      other_err++;
      s_valid <= 1'b0;
      $display("Timed out waiting for an upstream credit");
    end else begin
      s_valid <= 1'b1;
      {s_last, s_user, s_keep, s_data} <= b;
      up_credits--;
      beats_sent++;
      last_drive = cyc;
      exp_q.push_back(b);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge axi_aclk);
      s_valid <= 1'b0;
    end
  endtask

  // Packet with gap in the low user field; random idle between beats
  task automatic send_pkt(input int len, input int gap, input int idle_max);
    logic [104:0] b;
    for (int i = 0; i < len; i++) begin
      b[63:0]   = {next_rand(), next_rand()};
      b[71:64]  = (i == len - 1) ? 8'(next_rand() | 1) : 8'hff;
      b[103:72] = {16'(next_rand()), 16'(gap)};
      b[104]    = (i == len - 1);
      drive_beat(b);
      if (idle_max > 0) idle(int'(next_rand() % (idle_max + 1)));
    end
  endtask

  task automatic wait_drain();
    int t = 0;
    while (exp_q.size() != 0 && t < 20000) begin
      @(posedge axi_aclk);
      t++;
    end
    if (exp_q.size() != 0) begin
      other_err++;
      $display("Timed out draining %0d expected beats", exp_q.size());
    end
    idle(4);
  endtask

  task automatic wait_queue(input int n);
    int t = 0;
    while (exp_q.size() > n && t < 5000) begin
      @(posedge axi_aclk);
      t++;
    end
    if (exp_q.size() > n) begin
      other_err++;
      $display("Timed out waiting for the first packet to leave");
    end
  endtask

  initial begin
    {rst_n, sw_rst, ipd_en, use_reg_val, s_valid, s_last, m_credit} = '0;
    {s_data, s_keep, s_user, delay_reg_val} = '0;
    {cyc, err_cnt, other_err, credit_returns, beats_sent, granted, mbeats} = '0;
    {prev_start, prev_gap, last_start, last_drive, sw_cyc} = '0;
    {prev_valid, upper_chk, grant_next} = '0;
    out_first  = 1'b1;
    grant_on   = 1'b1;
    grant_fast = 1'b1;
    up_credits = 8;
    lcg_state  = 70;
    repeat (16) @(posedge axi_aclk);
    rst_n <= 1'b1;
    // Paced, gap from the user field
    ipd_en <= 1'b1;
    repeat (10) send_pkt(int'(next_rand() % 6) + 1, int'(next_rand() % 41), 3);
    idle(1);
    wait_drain();
    // Paced, register gap with a backlog
    prev_valid = 1'b0;
    use_reg_val <= 1'b1;
    delay_reg_val <= 16'd20;
    upper_chk = 1'b1;
    repeat (10) send_pkt(int'(next_rand() % 6) + 1, int'(next_rand() % 41), 0);
    idle(1);
    wait_drain();
    upper_chk = 1'b0;
    // Bypass, then latency on an idle pipe
    ipd_en <= 1'b0;
    use_reg_val <= 1'b0;
    repeat (8) send_pkt(int'(next_rand() % 6) + 1, int'(next_rand() % 41), 2);
    idle(1);
    wait_drain();
    send_pkt(1, 0, 0);
    idle(1);
    wait_drain();
    check_eq("bypass_latency", 128'(2), 128'(last_start - last_drive));
    // Withheld then slow downstream credits
    grant_on = 1'b0;
    fork
      begin
        repeat (5) send_pkt(6, int'(next_rand() % 41), 0);
        idle(1);
      end
      begin
        repeat (200) @(posedge axi_aclk);
        check_eq("upstream_stall", 128'(0), 128'(up_credits));
        grant_fast = 1'b0;
        grant_on   = 1'b1;
      end
    join
    wait_drain();
    grant_fast = 1'b1;
    // Restart while a packet waits on a long deadline
    ipd_en <= 1'b1;
    use_reg_val <= 1'b1;
    delay_reg_val <= 16'd300;
    idle(2);
    send_pkt(3, 0, 0);
    send_pkt(2, 0, 0);
    idle(1);
    wait_queue(2);
    idle(5);
    @(posedge axi_aclk);
    sw_rst <= 1'b1;
    sw_cyc = cyc;
    prev_valid = 1'b0;
    @(posedge axi_aclk);
    sw_rst <= 1'b0;
    wait_drain();
    check_eq("restart_latency", 128'(2), 128'(last_start - sw_cyc));
    // Every popped beat returns its credit
    check_eq("credit_returns", 128'(beats_sent), 128'(credit_returns));
    check_eq("upstream_credits", 128'(8), 128'(up_credits));
    $display("Errors: %0d mismatches, %0d other failures", err_cnt, other_err);
    if (err_cnt == 0 && other_err == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule : pkt_pacer_tb

`default_nettype wire

// ==== flist.f ====
common/stream_pkg.sv
common/pace_pkg.sv
hdl/ingress_buffer.sv
pacer/gap_timer.sv
pacer/pacer_fsm.sv
hdl/credit_egress.sv
hdl/pkt_pacer_top.sv
dv/pkt_pacer_props.sv
dv/pkt_pacer_tb.sv

// ==== Makefile ====
# Verilator simulation of the packet pacer testbench

TOP := pkt_pacer_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, fail unless it passes"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o sim
	./obj_dir/sim | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
